/* source/pipePkg.sv */
package pipePkg;

    // Datapath sizes
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int memDepth     = 256;
    localparam int memAddrWidth = 8;

    // RV32I major opcodes in the supported subset
    localparam logic [6:0] opReg   = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opLui   = 7'b0110111;

    // funct3 and funct7 codes
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [6:0] f7Sub    = 7'b0100000;

    // ALU operations
    localparam logic [2:0] aluAdd   = 3'd0;
    localparam logic [2:0] aluSub   = 3'd1;
    localparam logic [2:0] aluAnd   = 3'd2;
    localparam logic [2:0] aluOr    = 3'd3;
    localparam logic [2:0] aluXor   = 3'd4;
    localparam logic [2:0] aluSlt   = 3'd5;
    localparam logic [2:0] aluPassB = 3'd6;

    // Execute operand sources
    localparam logic [1:0] fwdRegFile = 2'b00;
    localparam logic [1:0] fwdWb      = 2'b01;
    localparam logic [1:0] fwdMem     = 2'b10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    // immLo sits where rd sits in the other two views
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormat;

    typedef union packed {
        rFormat rType;
        iFormat iType;
        sFormat sType;
    } instWord;

endpackage

/* source/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit (
    input  logic                              clk,
    input  logic                              rst,
    // Instruction in EX
    input  logic                              exUsesRs1,
    input  logic                              exUsesRs2,
    input  logic [pipePkg::regAddrWidth-1:0]  exRs1,
    input  logic [pipePkg::regAddrWidth-1:0]  exRs2,
    // Instruction in MEM
    input  logic                              memWritesReg,
    input  logic                              memIsLoad,
    input  logic [pipePkg::regAddrWidth-1:0]  memRd,
    // Instruction in WB
    input  logic                              wbWritesReg,
    input  logic [pipePkg::regAddrWidth-1:0]  wbRd,
    output logic [1:0]                        rs1Sel,
    output logic [1:0]                        rs2Sel,
    output logic                              loadUseStall
);

    // Set for the cycle after a stall, when EX/MEM holds a bubble with a stale rd
    logic bubbleInMem;

    function automatic logic [1:0] pickSource(input logic uses,
                                              input logic [pipePkg::regAddrWidth-1:0] src);
        logic memHit;
        logic memShadow;
        logic wbHit;
        memHit    = uses && memWritesReg && !memIsLoad && (memRd == src);
        // A younger write in MEM hides the WB value, unless MEM is a bubble
        memShadow = memWritesReg && (memRd == src) && !bubbleInMem;
        wbHit     = uses && wbWritesReg && (wbRd == src) && !memShadow;
        if (memHit)
            return pipePkg::fwdMem;
        else if (wbHit)
            return pipePkg::fwdWb;
        else
            return pipePkg::fwdRegFile;
    endfunction

    always_comb begin
        rs1Sel = pickSource(exUsesRs1, exRs1);
        rs2Sel = pickSource(exUsesRs2, exRs2);
    end

    // Load data is not ready until the load reaches WB
    assign loadUseStall = memIsLoad &&
                          ((exUsesRs1 && (memRd == exRs1)) || (exUsesRs2 && (memRd == exRs2)));

    always_ff @(posedge clk) begin
        if (rst) begin
            bubbleInMem <= 1'b0;
        end else begin
            bubbleInMem <= loadUseStall;
        end
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [pipePkg::regAddrWidth-1:0]  rdAddr1,
    input  logic [pipePkg::regAddrWidth-1:0]  rdAddr2,
    input  logic [pipePkg::regAddrWidth-1:0]  wrAddr,
    input  logic                              wrEn,
    input  logic [pipePkg::dataWidth-1:0]     wrData,
    output logic [pipePkg::dataWidth-1:0]     rdData1,
    output logic [pipePkg::dataWidth-1:0]     rdData2
);

    logic [pipePkg::dataWidth-1:0] regs [1 << pipePkg::regAddrWidth];

    // x0 reads zero, and a write in the same cycle is passed straight through
    function automatic logic [pipePkg::dataWidth-1:0] readPort(
        input logic [pipePkg::regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wrEn && (wrAddr == addr))
            return wrData;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << pipePkg::regAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        rdData1 = readPort(rdAddr1);
        rdData2 = readPort(rdAddr2);
    end

endmodule

/* source/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder (
    input  pipePkg::instWord                  inst,
    output logic [pipePkg::regAddrWidth-1:0]  rs1,
    output logic [pipePkg::regAddrWidth-1:0]  rs2,
    output logic [pipePkg::regAddrWidth-1:0]  rd,
    output logic [pipePkg::dataWidth-1:0]     imm,
    output logic [2:0]                        aluOp,
    output logic                              usesRs1,
    output logic                              usesRs2,
    output logic                              writesReg,
    output logic                              isLoad,
    output logic                              isStore,
    output logic                              useImm,
    output logic                              legal
);

    always_comb begin
        rs1       = inst.rType.rs1;
        rs2       = inst.rType.rs2;
        rd        = inst.rType.rd;
        imm       = '0;
        aluOp     = pipePkg::aluAdd;
        usesRs1   = 1'b0;
        usesRs2   = 1'b0;
        writesReg = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        useImm    = 1'b0;
        legal     = 1'b1;
        case (inst.rType.opcode)
            pipePkg::opReg: begin
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                writesReg = 1'b1;
                case (inst.rType.funct3)
                    pipePkg::f3AddSub: aluOp = (inst.rType.funct7 == pipePkg::f7Sub) ?
                                               pipePkg::aluSub : pipePkg::aluAdd;
                    pipePkg::f3Slt:    aluOp = pipePkg::aluSlt;
                    pipePkg::f3Xor:    aluOp = pipePkg::aluXor;
                    pipePkg::f3Or:     aluOp = pipePkg::aluOr;
                    pipePkg::f3And:    aluOp = pipePkg::aluAnd;
                    default:           legal = 1'b0;
                endcase
            end
            pipePkg::opImm: begin
                usesRs1   = 1'b1;
                writesReg = 1'b1;
                useImm    = 1'b1;
                imm       = {{20{inst.iType.imm[11]}}, inst.iType.imm};
                case (inst.iType.funct3)
                    pipePkg::f3AddSub: aluOp = pipePkg::aluAdd;
                    pipePkg::f3Xor:    aluOp = pipePkg::aluXor;
                    pipePkg::f3Or:     aluOp = pipePkg::aluOr;
                    pipePkg::f3And:    aluOp = pipePkg::aluAnd;
                    default:           legal = 1'b0;
                endcase
            end
            pipePkg::opLoad: begin
                usesRs1   = 1'b1;
                writesReg = 1'b1;
                isLoad    = 1'b1;
                useImm    = 1'b1;
                imm       = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            end
            pipePkg::opStore: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                isStore = 1'b1;
                useImm  = 1'b1;
                imm     = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
            end
            pipePkg::opLui: begin
                writesReg = 1'b1;
                useImm    = 1'b1;
                aluOp     = pipePkg::aluPassB;
                imm       = {inst.rType.funct7, inst.rType.rs2, inst.rType.rs1,
                             inst.rType.funct3, 12'b0};
            end
            default: legal = 1'b0;
        endcase
        // Unknown words retire as no-ops
        if (!legal) begin
            usesRs1   = 1'b0;
            usesRs2   = 1'b0;
            writesReg = 1'b0;
            isLoad    = 1'b0;
            isStore   = 1'b0;
        end
        // x0 is never a dependency or a destination
        if (rs1 == '0) usesRs1 = 1'b0;
        if (rs2 == '0) usesRs2 = 1'b0;
        if (rd == '0) writesReg = 1'b0;
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic [2:0]                     aluOp,
    input  logic [pipePkg::dataWidth-1:0]  opA,
    input  logic [pipePkg::dataWidth-1:0]  opB,
    output logic [pipePkg::dataWidth-1:0]  result
);

    always_comb begin
        case (aluOp)
            pipePkg::aluAdd:   result = opA + opB;
            pipePkg::aluSub:   result = opA - opB;
            pipePkg::aluAnd:   result = opA & opB;
            pipePkg::aluOr:    result = opA | opB;
            pipePkg::aluXor:   result = opA ^ opB;
            // Signed compare
            pipePkg::aluSlt: begin
                result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            // lui immediate passes through
            pipePkg::aluPassB: result = opB;
            default:           result = '0;
        endcase
    end

endmodule

/* source/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
    input  logic                              clk,
    input  logic                              wrEn,
    input  logic [pipePkg::memAddrWidth-1:0]  addr,
    input  logic [pipePkg::dataWidth-1:0]     wrData,
    output logic [pipePkg::dataWidth-1:0]     rdData
);

    // Word array, addressed by the byte address with its low two bits dropped
    logic [pipePkg::dataWidth-1:0] mem [pipePkg::memDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    // Read is combinational so the load result is ready within MEM
    assign rdData = mem[addr];

endmodule

/* source/pipeCore.sv */
`timescale 1ns/1ps

module pipeCore (
    input  logic                              clk,
    input  logic                              rst,
    output logic [29:0]                       fetchAddr,
    input  logic [pipePkg::dataWidth-1:0]     fetchData,
    output logic                              traceValid,
    output logic [pipePkg::regAddrWidth-1:0]  traceRd,
    output logic [pipePkg::dataWidth-1:0]     traceData
);

    localparam int dw = pipePkg::dataWidth;
    localparam int aw = pipePkg::regAddrWidth;

    // Fetch and IF/ID
    logic [29:0]      pc;
    logic             fetchValid;
    logic             ifIdValid;
    pipePkg::instWord ifIdInst;

    // Decode outputs
    logic [aw-1:0] decRs1, decRs2, decRd;
    logic [dw-1:0] decImm, rfData1, rfData2;
    logic [2:0]    decAluOp;
    logic          decUsesRs1, decUsesRs2, decWritesReg;
    logic          decIsLoad, decIsStore, decUseImm, decLegal;
    logic          idValid;

    // ID/EX
    logic          exValid;
    logic [aw-1:0] exRs1, exRs2, exRd;
    logic [dw-1:0] exImm, exRsData1, exRsData2;
    logic [2:0]    exAluOp;
    logic          exUsesRs1, exUsesRs2, exWritesReg, exIsLoad, exIsStore, exUseImm;

    // Execute
    logic [1:0]    rs1Sel, rs2Sel;
    logic          loadUseStall;
    logic [dw-1:0] rs1Value, rs2Value, aluB, exResult;

    // EX/MEM
    logic          memValid, memWritesReg, memIsLoad, memIsStore;
    logic [aw-1:0] memRd;
    logic [dw-1:0] memAluResult, memStoreData, memLoadData;

    // MEM/WB
    logic          wbValid, wbWritesReg, wbIsLoad, wbWrite;
    logic [aw-1:0] wbRd;
    logic [dw-1:0] wbAluResult, wbLoadData, wbData;

    function automatic logic [dw-1:0] pickOperand(input logic [1:0] sel,
                                                  input logic [dw-1:0] regVal,
                                                  input logic [dw-1:0] memVal,
                                                  input logic [dw-1:0] wbVal);
        case (sel)
            pipePkg::fwdMem: return memVal;
            pipePkg::fwdWb:  return wbVal;
            default:         return regVal;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////////////////////////

    // On a stall the word now on fetchData is asked for again, so it is not lost
    assign fetchAddr = loadUseStall ? pc - 30'd1 : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            fetchValid <= 1'b0;
            ifIdValid  <= 1'b0;
        end else if (!loadUseStall) begin
            pc         <= pc + 30'd1;
            fetchValid <= 1'b1;
            ifIdValid  <= fetchValid;
            ifIdInst   <= fetchData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    instDecoder dec0 (
        .inst(ifIdInst), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
        .aluOp(decAluOp), .usesRs1(decUsesRs1), .usesRs2(decUsesRs2),
        .writesReg(decWritesReg), .isLoad(decIsLoad), .isStore(decIsStore),
        .useImm(decUseImm), .legal(decLegal)
    );

    regFile rf0 (
        .clk(clk), .rst(rst), .rdAddr1(decRs1), .rdAddr2(decRs2),
        .wrAddr(wbRd), .wrEn(wbWrite), .wrData(wbData),
        .rdData1(rfData1), .rdData2(rfData2)
    );

    assign idValid = ifIdValid && decLegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid     <= 1'b0;
            exUsesRs1   <= 1'b0;
            exUsesRs2   <= 1'b0;
            exWritesReg <= 1'b0;
            exIsLoad    <= 1'b0;
            exIsStore   <= 1'b0;
        end else if (loadUseStall) begin
            // Hold, but keep operands resolved now since WB retires this cycle
            exRsData1 <= rs1Value;
            exRsData2 <= rs2Value;
        end else begin
            exValid     <= idValid;
            exUsesRs1   <= idValid && decUsesRs1;
            exUsesRs2   <= idValid && decUsesRs2;
            exWritesReg <= idValid && decWritesReg;
            exIsLoad    <= idValid && decIsLoad;
            exIsStore   <= idValid && decIsStore;
            exUseImm    <= decUseImm;
            exAluOp     <= decAluOp;
            exRs1       <= decRs1;
            exRs2       <= decRs2;
            exRd        <= decRd;
            exImm       <= decImm;
            exRsData1   <= rfData1;
            exRsData2   <= rfData2;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    forwardUnit fwd0 (
        .clk(clk), .rst(rst),
        .exUsesRs1(exUsesRs1), .exUsesRs2(exUsesRs2), .exRs1(exRs1), .exRs2(exRs2),
        .memWritesReg(memWritesReg), .memIsLoad(memIsLoad), .memRd(memRd),
        .wbWritesReg(wbWrite), .wbRd(wbRd),
        .rs1Sel(rs1Sel), .rs2Sel(rs2Sel), .loadUseStall(loadUseStall)
    );

    assign rs1Value = pickOperand(rs1Sel, exRsData1, memAluResult, wbData);
    assign rs2Value = pickOperand(rs2Sel, exRsData2, memAluResult, wbData);
    assign aluB     = exUseImm ? exImm : rs2Value;

    aluUnit alu0 (.aluOp(exAluOp), .opA(rs1Value), .opB(aluB), .result(exResult));

    // A stall sends a bubble on, rd stays as the load left it
    always_ff @(posedge clk) begin
        if (rst) begin
            memValid     <= 1'b0;
            memWritesReg <= 1'b0;
            memIsLoad    <= 1'b0;
            memIsStore   <= 1'b0;
        end else begin
            memValid     <= exValid && !loadUseStall;
            memWritesReg <= exWritesReg && !loadUseStall;
            memIsLoad    <= exIsLoad && !loadUseStall;
            memIsStore   <= exIsStore && !loadUseStall;
            memAluResult <= exResult;
            memStoreData <= rs2Value;
            if (!loadUseStall) begin
                memRd <= exRd;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////////////////////////

    dataMemory dmem0 (
        .clk(clk), .wrEn(memIsStore),
        .addr(memAluResult[pipePkg::memAddrWidth+1:2]),
        .wrData(memStoreData), .rdData(memLoadData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid     <= 1'b0;
            wbWritesReg <= 1'b0;
        end else begin
            wbValid     <= memValid;
            wbWritesReg <= memWritesReg;
            wbIsLoad    <= memIsLoad;
            wbRd        <= memRd;
            wbAluResult <= memAluResult;
            wbLoadData  <= memLoadData;
        end
    end

    assign wbData  = wbIsLoad ? wbLoadData : wbAluResult;
    assign wbWrite = wbValid && wbWritesReg;

    // Every retiring register write shows on the trace
    assign traceValid = wbWrite;
    assign traceRd    = wbRd;
    assign traceData  = wbData;

endmodule

/* sim/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference machine
logic [31:0] modelRegs [32];
logic [31:0] modelMem [256];

// Word slot for a byte address, wrapping over the 256-word array
function automatic int wordIndex(input logic [31:0] byteAddr);
    return (byteAddr >> 2) % 256;
endfunction

// Executes one RV32I instruction of the subset
// rd comes back as zero when no register is written
function automatic void stepModel(input logic [31:0] word, output logic [4:0] rd,
                                  output logic [31:0] value);
    pipePkg::instWord inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    inst  = word;
    a     = modelRegs[inst.rType.rs1];
    b     = modelRegs[inst.rType.rs2];
    immI  = $signed(inst.iType.imm);
    immS  = $signed({inst.sType.immHi, inst.sType.immLo});
    rd    = 5'd0;
    value = 32'd0;
    case (inst.rType.opcode)
        7'b0110011: begin
            rd = inst.rType.rd;
            case (inst.rType.funct3)
                3'b000:  value = (inst.rType.funct7 == 7'b0100000) ? a - b : a + b;
                3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  value = a ^ b;
                3'b110:  value = a | b;
                3'b111:  value = a & b;
                default: rd = 5'd0;
            endcase
        end
        7'b0010011: begin
            rd = inst.iType.rd;
            case (inst.iType.funct3)
                3'b000:  value = a + immI;
                3'b100:  value = a ^ immI;
                3'b110:  value = a | immI;
                3'b111:  value = a & immI;
                default: rd = 5'd0;
            endcase
        end
        7'b0000011: begin
            rd    = inst.iType.rd;
            value = modelMem[wordIndex(a + immI)];
        end
        7'b0100011: modelMem[wordIndex(a + immS)] = b;
        7'b0110111: begin
            rd    = inst.rType.rd;
            value = {word[31:12], 12'b0};
        end
        default: rd = 5'd0;
    endcase
    // x0 stays zero
    if (rd != 5'd0)
        modelRegs[rd] = value;
endfunction

`endif

/* sim/pipeCoreTb.sv */
`timescale 1ns/1ps

module pipeCoreTb;

    localparam logic [31:0] nopWord   = 32'h0000_0013;
    localparam int          progDepth = 128;
    localparam int          waitLimit = 200;

    logic        clk;
    logic        rst;
    logic [29:0] fetchAddr;
    logic [31:0] fetchData;
    logic        traceValid;
    logic [4:0]  traceRd;
    logic [31:0] traceData;

    logic [31:0] progMem [progDepth];
    int          progLen;
    string       currentTest;
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    int          cycleCount;
    int          startCycle;
    int          lastTraceCycle;
    int          checkCount;
    int          errorCount;
    int          otherFails;
    integer      seed;

    `include "isaModel.svh"

    pipeCore dut0 (
        .clk(clk), .rst(rst), .fetchAddr(fetchAddr), .fetchData(fetchData),
        .traceValid(traceValid), .traceRd(traceRd), .traceData(traceData)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Synchronous instruction ROM, nops past the program end
    always @(posedge clk) begin
        if (fetchAddr < progLen)
            fetchData <= progMem[fetchAddr];
        else
            fetchData <= nopWord;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], pipePkg::opReg};
    endfunction

    function automatic logic [31:0] immOp(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], pipePkg::opImm};
    endfunction

    function automatic logic [31:0] addImm(input int rd, input int rs1, input int imm);
        return immOp(pipePkg::f3AddSub, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] loadWord(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], pipePkg::opLoad};
    endfunction

    function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], pipePkg::opStore};
    endfunction

    function automatic logic [31:0] upperImm(input int rd, input logic [19:0] imm20);
        return {imm20, rd[4:0], pipePkg::opLui};
    endfunction

    // A load directly followed by a reader of its rd costs one cycle
    function automatic bit loadUseHazard(input pipePkg::instWord prev,
                                         input pipePkg::instWord cur);
        bit readsRs1;
        bit readsRs2;
        if (prev.iType.opcode != pipePkg::opLoad || prev.iType.rd == 5'd0)
            return 1'b0;
        readsRs2 = (cur.rType.opcode == pipePkg::opReg) || (cur.rType.opcode == pipePkg::opStore);
        readsRs1 = readsRs2 || (cur.rType.opcode == pipePkg::opImm) ||
                   (cur.rType.opcode == pipePkg::opLoad);
        return (readsRs1 && cur.rType.rs1 == prev.iType.rd) ||
               (readsRs2 && cur.rType.rs2 == prev.iType.rd);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %h, actual %h", currentTest, label,
                     expected, actual);
        end
    endtask

    // Trace monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0 && traceValid === 1'b1) begin
            lastTraceCycle = cycleCount;
            if (expRd.size() == 0) begin
                otherFails++;
                $display("Extra register write in %s: x%0d = %h was not expected",
                         currentTest, traceRd, traceData);
            end else begin
                checkValue("trace rd", expRd.pop_front(), traceRd);
                checkValue("trace data", expData.pop_front(), traceData);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic beginProgram(input string name);
        @(posedge clk);
        rst <= 1'b1;
        currentTest = name;
        progLen = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        progMem[progLen] = word;
        progLen++;
    endtask

    task automatic emitRandom();
        int          kind;
        int          rd;
        int          rs1;
        int          rs2;
        int          imm;
        logic [19:0] upper;
        kind  = ($random(seed) & 32'h7fff_ffff) % 13;
        rd    = $random(seed) & 7;
        rs1   = $random(seed) & 7;
        rs2   = $random(seed) & 7;
        imm   = $random(seed) % 2048;
        upper = $random(seed);
        case (kind)
            0:  emit(regOp(7'h00, pipePkg::f3AddSub, rd, rs1, rs2));
            1:  emit(regOp(pipePkg::f7Sub, pipePkg::f3AddSub, rd, rs1, rs2));
            2:  emit(regOp(7'h00, pipePkg::f3And, rd, rs1, rs2));
            3:  emit(regOp(7'h00, pipePkg::f3Or, rd, rs1, rs2));
            4:  emit(regOp(7'h00, pipePkg::f3Xor, rd, rs1, rs2));
            5:  emit(regOp(7'h00, pipePkg::f3Slt, rd, rs1, rs2));
            6:  emit(addImm(rd, rs1, imm));
            7:  emit(immOp(pipePkg::f3And, rd, rs1, imm));
            8:  emit(immOp(pipePkg::f3Or, rd, rs1, imm));
            9:  emit(immOp(pipePkg::f3Xor, rd, rs1, imm));
            10: emit(upperImm(rd, upper));
            // Memory ops stay within the first 64 words
            11: emit(loadWord(rd, 0, (imm & 63) * 4));
            default: emit(storeWord(rs2, 0, (imm & 63) * 4));
        endcase
    endtask

    // Model the program, release reset and wait for the last retirement
    task automatic runProgram();
        logic [4:0]  rd;
        logic [31:0] value;
        int          i;
        int          stalls;
        int          endCycles;
        int          waited;
        bit          lastWrites;
        expRd.delete();
        expData.delete();
        stalls = 0;
        lastWrites = 1'b0;
        for (i = 0; i < 32; i++)
            modelRegs[i] = 32'd0;
        for (i = 0; i < progLen; i++) begin
            stepModel(progMem[i], rd, value);
            if (rd != 5'd0) begin
                expRd.push_back(rd);
                expData.push_back(value);
            end
            lastWrites = (rd != 5'd0);
            if (i > 0 && loadUseHazard(progMem[i-1], progMem[i]))
                stalls++;
        end
        endCycles = progLen + stalls + 4;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        startCycle = cycleCount;
        lastTraceCycle = startCycle;
        waited = 0;
        while ((expRd.size() != 0 || cycleCount < startCycle + endCycles + 2) &&
               waited < waitLimit) begin
            @(posedge clk);
            waited++;
        end
        if (expRd.size() != 0) begin
            otherFails++;
            $display("Timeout in %s: %0d register writes did not retire within %0d cycles",
                     currentTest, expRd.size(), waitLimit);
            expRd.delete();
            expData.delete();
        end else if (lastWrites) begin
            checkValue("end cycle", endCycles, lastTraceCycle - startCycle);
        end
    endtask

    initial begin
        int k;
        int run;
        clk = 1'b0;
        rst = 1'b1;
        fetchData = nopWord;
        progLen = 0;
        cycleCount = 0;
        checkCount = 0;
        errorCount = 0;
        otherFails = 0;
        seed = 28;
        currentTest = "idle";

        // Data memory has no reset
        beginProgram("memory clear");
        for (k = 0; k < 64; k++)
            emit(storeWord(0, 0, k * 4));
        runProgram();

        beginProgram("back-to-back alu");
        emit(addImm(1, 0, 100));
        emit(addImm(2, 0, 7));
        emit(regOp(7'h00, pipePkg::f3AddSub, 3, 1, 2));
        emit(regOp(pipePkg::f7Sub, pipePkg::f3AddSub, 4, 3, 1));
        emit(regOp(pipePkg::f7Sub, pipePkg::f3AddSub, 5, 2, 4));
        emit(regOp(7'h00, pipePkg::f3Or, 6, 5, 4));
        runProgram();

        beginProgram("distance two and x0");
        emit(addImm(1, 0, 5));
        emit(addImm(2, 0, 9));
        emit(regOp(7'h00, pipePkg::f3AddSub, 3, 1, 0));
        emit(addImm(1, 0, 20));
        emit(addImm(1, 0, 30));
        // Younger x1 must win
        emit(regOp(7'h00, pipePkg::f3AddSub, 4, 1, 1));
        emit(addImm(0, 0, 7));
        emit(regOp(7'h00, pipePkg::f3AddSub, 5, 0, 0));
        emit(regOp(7'h00, pipePkg::f3Or, 6, 0, 2));
        emit(regOp(pipePkg::f7Sub, pipePkg::f3AddSub, 7, 2, 3));
        runProgram();

        beginProgram("load-use");
        emit(addImm(1, 0, 123));
        emit(storeWord(1, 0, 8));
        emit(addImm(2, 0, -5));
        emit(storeWord(2, 0, 12));
        emit(loadWord(3, 0, 8));
        emit(regOp(7'h00, pipePkg::f3AddSub, 4, 3, 1));
        emit(loadWord(5, 0, 12));
        emit(regOp(pipePkg::f7Sub, pipePkg::f3AddSub, 6, 1, 5));
        emit(loadWord(7, 0, 8));
        emit(storeWord(7, 0, 16));
        emit(loadWord(1, 0, 16));
        emit(addImm(2, 1, 1));
        runProgram();

        beginProgram("store and wrapped load");
        emit(addImm(1, 0, 32'h55));
        emit(storeWord(1, 0, 20));
        emit(upperImm(2, 20'hABCDE));
        emit(storeWord(2, 0, 1044));
        emit(addImm(3, 0, 1024));
        emit(addImm(4, 0, -7));
        emit(storeWord(4, 3, 24));
        emit(loadWord(5, 0, 20));
        emit(loadWord(6, 0, 24));
        emit(loadWord(7, 3, 20));
        emit(regOp(7'h00, pipePkg::f3AddSub, 1, 5, 6));
        runProgram();

        beginProgram("immediate forms");
        emit(upperImm(1, 20'h80000));
        emit(addImm(2, 0, -1));
        emit(immOp(pipePkg::f3And, 3, 2, 240));
        emit(immOp(pipePkg::f3Or, 4, 3, -256));
        emit(immOp(pipePkg::f3Xor, 5, 4, 2047));
        emit(regOp(7'h00, pipePkg::f3Slt, 6, 1, 2));
        emit(regOp(7'h00, pipePkg::f3Slt, 7, 2, 1));
        emit(addImm(2, 1, -2048));
        emit(regOp(7'h00, pipePkg::f3Slt, 3, 1, 2));
        emit(upperImm(4, 20'hFFFFF));
        emit(immOp(pipePkg::f3Xor, 4, 4, -1));
        runProgram();

        for (run = 0; run < 3; run++) begin
            beginProgram($sformatf("random program %0d", run));
            repeat (40) emitRandom();
            runProgram();
        end

        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checkCount, errorCount, otherFails);
        if (errorCount == 0 && otherFails == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* pipeCore.f */
+incdir+sim
source/pipePkg.sv
source/forwardUnit.sv
source/regFile.sv
source/instDecoder.sv
source/aluUnit.sv
source/dataMemory.sv
source/pipeCore.sv
sim/pipeCoreTb.sv

/* Bender.yml */
package:
  name: pipeCore

sources:
  - source/pipePkg.sv
  - source/forwardUnit.sv
  - source/regFile.sv
  - source/instDecoder.sv
  - source/aluUnit.sv
  - source/dataMemory.sv
  - source/pipeCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/pipeCoreTb.sv
